/* fetch_top.f */
+incdir+rtl
rtl/fetch_pkg.sv
rtl/redirect_hold.sv
rtl/pc_gen.sv
rtl/stage_reg.sv
rtl/inst_resp.sv
rtl/fetch_top.sv
testbench/isram_model.sv
testbench/fetch_tb.sv

/* testbench/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int NUM_ROWS   = 10;
    localparam int WAIT_LIMIT = 2000;

    localparam logic [2:0] K_NONE   = 3'd0;
    localparam logic [2:0] K_BR     = 3'd1;
    localparam logic [2:0] K_EXC    = 3'd2;
    localparam logic [2:0] K_ERTN   = 3'd3;
    localparam logic [2:0] K_EXC_BR = 3'd4;   // branch goes to target + 0x40.

    typedef struct packed {
        logic [7:0]  pkts;        // packets before the redirect.
        logic [2:0]  kind;
        logic [31:0] target;
        logic [7:0]  stall_len;
        logic [3:0]  addr_dly;
        logic [3:0]  data_dly;
        logic [7:0]  bp_pct;      // percent of cycles decode refuses.
    } row_t;

    logic                     clk;
    logic                     resetn;
    redirect_t                exc;
    redirect_t                ertn;
    branch_fb_t               br;
    isram_req_t               isram_req;
    logic [1:0]               isram_size;
    logic                     addr_ok;
    logic                     data_ok;
    logic [`FETCH_INST_W-1:0] rdata;
    logic                     out_valid;
    fetch_pkt_t               out_pkt;
    logic                     decode_allowin = 1'b1;

    int unsigned addr_delay;
    int unsigned data_delay;
    int unsigned bp_pct;
    row_t        rows [NUM_ROWS];
    logic [31:0] exp_pc       = `FETCH_RESET_PC;
    logic        req_waiting  = 1'b0;
    int          delivered    = 0;
    int          stall_reqs   = 0;
    int          reset_valids = 0;
    int          reset_reqs   = 0;
    int          pkt_errors   = 0;
    int          count_errors = 0;
    int          size_errors  = 0;
    int          timeouts     = 0;

    fetch_top dut_i (.*);

    isram_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // expected values and compares
    // ------------------------------------------------------------

    function automatic fetch_pkt_t expect_pkt(input logic [31:0] pc);
        fetch_pkt_t p;
        p.pc       = pc;
        p.inst     = ~pc;
        p.adef     = (pc % 32'd4) != 0;
        p.bad_addr = pc;
        return p;
    endfunction

    task automatic check_pkt(input string name, input fetch_pkt_t got, input fetch_pkt_t exp);
        logic ok;
        ok = (got.pc === exp.pc) && (got.inst === exp.inst) && (got.adef === exp.adef);
        if (exp.adef) ok = ok && (got.bad_addr === exp.bad_addr);   // only meaningful on adef.
        if (!ok) begin
            pkt_errors++;
            $display("Fail %0t %s: got %h/%h/%b/%h expected %h/%h/%b/%h (pc/inst/adef/bad)",
                     $time, name, got.pc, got.inst, got.adef, got.bad_addr,
                     exp.pc, exp.inst, exp.adef, exp.bad_addr);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errors++;
            $display("Fail %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_size(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            size_errors++;
            $display("Fail %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic wait_packets(input int n);
        int start;
        int cycles;
        @(negedge clk);
        start  = delivered;
        cycles = 0;
        while (delivered < start + n && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (delivered < start + n) begin
            timeouts++;
            $display("Timeout at %0t: only %0d of %0d packets reached decode",
                     $time, delivered - start, n);
        end
    endtask

    task automatic run_row(input row_t r);
        @(posedge clk);
        addr_delay <= r.addr_dly;
        data_delay <= r.data_dly;
        bp_pct     <= r.bp_pct;
        wait_packets(r.pkts);
        @(posedge clk);
        if (r.stall_len != 0) begin
            br.stall <= 1'b1;
            repeat (r.stall_len) @(posedge clk);
            br.stall <= 1'b0;
        end
        exc.target  <= r.target;
        ertn.target <= r.target;
        br.target   <= (r.kind == K_EXC_BR) ? r.target + 32'h40 : r.target;
        exc.valid   <= (r.kind == K_EXC) || (r.kind == K_EXC_BR);
        ertn.valid  <= (r.kind == K_ERTN);
        br.taken    <= (r.kind == K_BR) || (r.kind == K_EXC_BR);
        @(posedge clk);
        exc.valid  <= 1'b0;   // single-cycle pulse.
        ertn.valid <= 1'b0;
        br.taken   <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // monitor and decode back-pressure
    // ------------------------------------------------------------

    always @(posedge clk) begin
        if (!resetn) begin
            if (out_valid === 1'b1) reset_valids++;
            if (isram_req.req === 1'b1) reset_reqs++;
        end else begin
            // no new request may start under a branch stall.
            if (br.stall && isram_req.req && !req_waiting) stall_reqs++;
            req_waiting = isram_req.req && !addr_ok;
            if (isram_req.req) compare_size("isram_size", isram_size, 2'd2);   // word access.
            if (out_valid && decode_allowin) begin
                check_pkt("out_pkt", out_pkt, expect_pkt(exp_pc));
                exp_pc = exp_pc + 32'd4;
                delivered++;
            end
            if (exc.valid) exp_pc = exc.target;   // winning redirect.
            else if (ertn.valid) exp_pc = ertn.target;
            else if (br.taken) exp_pc = br.target;
        end
    end

    initial begin
        void'($urandom(77));
        forever begin
            @(posedge clk);
            if (resetn) decode_allowin <= ($urandom % 100) >= bp_pct;
        end
    end

    initial begin
        resetn     = 1'b0;
        exc        = '0;
        ertn       = '0;
        br         = '0;
        addr_delay = 0;
        data_delay = 1;
        bp_pct     = 0;
        //          pkts   kind      target        stall  addr  data  bp
        rows[0] = {8'd6, K_NONE,   32'h00000000, 8'd0, 4'd0, 4'd1, 8'd0};
        rows[1] = {8'd4, K_BR,     32'h1c000100, 8'd0, 4'd0, 4'd1, 8'd0};
        rows[2] = {8'd4, K_EXC,    32'h1c008000, 8'd0, 4'd1, 4'd2, 8'd0};
        rows[3] = {8'd4, K_ERTN,   32'h1c000200, 8'd0, 4'd2, 4'd3, 8'd0};
        rows[4] = {8'd3, K_BR,     32'h1c000300, 8'd0, 4'd0, 4'd4, 8'd30};
        rows[5] = {8'd3, K_EXC_BR, 32'h1c00a000, 8'd0, 4'd1, 4'd1, 8'd0};
        rows[6] = {8'd8, K_NONE,   32'h00000000, 8'd6, 4'd1, 4'd1, 8'd50};
        rows[7] = {8'd5, K_ERTN,   32'h1c000600, 8'd0, 4'd3, 4'd2, 8'd60};
        rows[8] = {8'd4, K_BR,     32'h1c000402, 8'd5, 4'd1, 4'd2, 8'd20};   // misaligned.
        rows[9] = {8'd4, K_EXC,    32'h1c000800, 8'd0, 4'd0, 4'd1, 8'd40};
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 0; i < NUM_ROWS && timeouts == 0; i++) begin
            run_row(rows[i]);
        end
        if (timeouts == 0) begin
            wait_packets(6);
        end
        check_count("out_valid_in_reset", reset_valids, 0);
        check_count("req_in_reset", reset_reqs, 0);
        check_count("stall_reqs", stall_reqs, 0);
        $display("errors: packet %0d, count %0d, size %0d, timeout %0d",
                 pkt_errors, count_errors, size_errors, timeouts);
        if (pkt_errors == 0 && count_errors == 0 && size_errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* testbench/isram_model.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module isram_model (
    input  logic                      clk,
    input  logic                      resetn,
    input  fetch_pkg::isram_req_t     isram_req,
    output logic                      addr_ok,
    output logic                      data_ok = 1'b0,
    output logic [`FETCH_INST_W-1:0]  rdata = '0,
    input  int unsigned               addr_delay,
    input  int unsigned               data_delay
);
    logic [31:0] addr_q [$];   // accepted reads, oldest first.
    int unsigned due_q [$];
    int unsigned cycle;
    int unsigned wait_cnt;     // cycles the current request has waited.
    logic [31:0] head_addr;

    assign addr_ok = isram_req.req && (wait_cnt >= addr_delay);

    always @(posedge clk) begin
        if (!resetn) begin
            cycle    <= 0;
            wait_cnt <= 0;
            data_ok  <= 1'b0;
            rdata    <= '0;
            addr_q.delete();
            due_q.delete();
        end else begin
            cycle <= cycle + 1;
            if (isram_req.req && addr_ok) begin
                addr_q.push_back(isram_req.addr);
                due_q.push_back(cycle + data_delay);
                wait_cnt <= 0;
            end else if (isram_req.req) begin
                wait_cnt <= wait_cnt + 1;
            end
            data_ok <= 1'b0;
            // responses in order, word at A reads as ~A.
            if (addr_q.size() > 0 && cycle + 1 >= due_q[0]) begin
                head_addr = addr_q.pop_front();
                due_q.delete(0);
                data_ok  <= 1'b1;
                rdata    <= ~head_addr;
            end
        end
    end

endmodule

/* rtl/fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_top (
    input  logic                      clk,
    input  logic                      resetn,
    input  fetch_pkg::redirect_t      exc,
    input  fetch_pkg::redirect_t      ertn,
    input  fetch_pkg::branch_fb_t     br,
    output fetch_pkg::isram_req_t     isram_req,
    output logic [1:0]                isram_size,
    input  logic                      addr_ok,
    input  logic                      data_ok,
    input  logic [`FETCH_INST_W-1:0]  rdata,
    output logic                      out_valid,
    output fetch_pkg::fetch_pkt_t     out_pkt,
    input  logic                      decode_allowin
);
    import fetch_pkg::*;

    logic [31:0] next_pc;
    logic [31:0] seq_pc;
    logic        any_redirect;
    logic        issue_accepted;

    logic        req_valid;
    fetch_req_t  req;
    logic        req_allowin;

    logic        stage_valid;
    fetch_req_t  stage_req;
    logic        resp_allowin;

    logic        pkt_valid;
    fetch_pkt_t  pkt;
    logic        pkt_allowin;

    assign isram_size = `FETCH_SRAM_SIZE;

    redirect_hold redirect_i (
        .clk            (clk),
        .resetn         (resetn),
        .exc            (exc),
        .ertn           (ertn),
        .br             (br),
        .issue_accepted (issue_accepted),
        .seq_pc         (seq_pc),
        .next_pc        (next_pc),
        .any_redirect   (any_redirect)
    );

    pc_gen pc_gen_i (
        .clk            (clk),
        .resetn         (resetn),
        .next_pc        (next_pc),
        .br_stall       (br.stall),
        .stage_allowin  (req_allowin),
        .any_redirect   (any_redirect),
        .isram_req      (isram_req),
        .addr_ok        (addr_ok),
        .issue_accepted (issue_accepted),
        .seq_pc         (seq_pc),
        .req_valid      (req_valid),
        .req            (req)
    );

    // requests waiting for their data.
    stage_reg #(.payload_t(fetch_req_t)) req_stage_i (
        .clk         (clk),
        .resetn      (resetn),
        .flush       (any_redirect),
        .in_valid    (req_valid),
        .in_data     (req),
        .allowin     (req_allowin),
        .out_valid   (stage_valid),
        .out_data    (stage_req),
        .out_allowin (resp_allowin)
    );

    inst_resp inst_resp_i (
        .clk          (clk),
        .resetn       (resetn),
        .any_redirect (any_redirect),
        .in_valid     (stage_valid),
        .in_req       (stage_req),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .resp_allowin (resp_allowin),
        .out_valid    (pkt_valid),
        .out_pkt      (pkt),
        .out_allowin  (pkt_allowin)
    );

    stage_reg #(.payload_t(fetch_pkt_t)) out_stage_i (
        .clk         (clk),
        .resetn      (resetn),
        .flush       (any_redirect),
        .in_valid    (pkt_valid),
        .in_data     (pkt),
        .allowin     (pkt_allowin),
        .out_valid   (out_valid),
        .out_data    (out_pkt),
        .out_allowin (decode_allowin)
    );

endmodule

/* rtl/inst_resp.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module inst_resp (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      any_redirect,
    input  logic                      in_valid,
    input  fetch_pkg::fetch_req_t     in_req,
    input  logic                      data_ok,
    input  logic [`FETCH_INST_W-1:0]  rdata,
    output logic                      resp_allowin,
    output logic                      out_valid,
    output fetch_pkg::fetch_pkt_t     out_pkt,
    input  logic                      out_allowin
);
    logic                      discard;
    logic                      buf_valid;
    logic [`FETCH_INST_W-1:0]  buf_inst;
    logic                      ready;
    logic                      waiting;
    logic                      capture;

    // ------------------------------------------------------------
    // response tracking
    // ------------------------------------------------------------

    assign ready = (data_ok | buf_valid) & !discard;

    // live request in the slot still without its data.
    assign waiting = in_valid & !buf_valid & !(data_ok & !discard);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            discard <= 1'b0;
        end else if (any_redirect) begin
            discard <= waiting | (discard & !data_ok);
        end else if (data_ok) begin
            discard <= 1'b0;   // stale response consumed.
        end
    end

    // ------------------------------------------------------------
    // instruction buffer
    // ------------------------------------------------------------

    assign capture = in_valid & data_ok & !discard & !buf_valid
                   & !out_allowin & !any_redirect;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
        end else if (any_redirect) begin
            buf_valid <= 1'b0;
        end else if (out_valid && out_allowin) begin
            buf_valid <= 1'b0;
        end else if (capture) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_inst <= rdata;
        end
    end

    // ------------------------------------------------------------
    // packet out
    // ------------------------------------------------------------

    // old path content is dropped in the redirect cycle.
    assign out_valid    = in_valid & ready & !any_redirect;
    assign resp_allowin = ready & out_allowin;

    assign out_pkt.pc       = in_req.pc;
    assign out_pkt.inst     = buf_valid ? buf_inst : rdata;
    assign out_pkt.adef     = in_req.adef;
    assign out_pkt.bad_addr = in_req.bad_addr;

endmodule

/* rtl/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     allowin,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_allowin
);
    logic     valid;
    payload_t data;

    // empty, or the current entry leaves this cycle.
    assign allowin = !valid || out_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;   // a new entry survives a flush.
        end else if (flush) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (allowin && in_valid) begin
            data <= in_data;
        end
    end

    assign out_valid = valid;
    assign out_data  = data;

endmodule

/* rtl/pc_gen.sv */
`timescale 1ns/1ps
`include "fetch_config.svh"

module pc_gen (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [31:0]            next_pc,
    input  logic                   br_stall,
    input  logic                   stage_allowin,
    input  logic                   any_redirect,
    output fetch_pkg::isram_req_t  isram_req,
    input  logic                   addr_ok,
    output logic                   issue_accepted,
    output logic [31:0]            seq_pc,
    output logic                   req_valid,
    output fetch_pkg::fetch_req_t  req
);
    logic [31:0] pc;
    logic        pending;     // accepted, not yet past the stage slot.
    logic        req_hold;    // raised earlier, waiting for addr_ok.
    logic        req_raise;

    // ------------------------------------------------------------
    // request side
    // ------------------------------------------------------------

    // no request while in reset.
    assign req_raise = resetn & (req_hold | (!pending && !br_stall && stage_allowin));

    assign isram_req.req  = req_raise;
    assign isram_req.addr = next_pc;

    assign issue_accepted = req_raise & addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_hold <= 1'b0;
        end else begin
            req_hold <= req_raise & !addr_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= 1'b0;
        end else if (issue_accepted) begin
            pending <= 1'b1;
        end else if (any_redirect || stage_allowin) begin
            pending <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // program counter
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= `FETCH_RESET_PC - 32'd4;   // first seq_pc is the reset pc.
        end else if (issue_accepted) begin
            pc <= next_pc;
        end
    end

    assign seq_pc = pc + 32'd4;

    // accepted request goes to the stage slot at the next edge.
    assign req_valid    = issue_accepted;
    assign req.pc       = next_pc;
    assign req.adef     = next_pc[1] | next_pc[0];
    assign req.bad_addr = next_pc;

endmodule

/* rtl/redirect_hold.sv */
`timescale 1ns/1ps

module redirect_hold (
    input  logic                  clk,
    input  logic                  resetn,
    input  fetch_pkg::redirect_t  exc,
    input  fetch_pkg::redirect_t  ertn,
    input  fetch_pkg::branch_fb_t br,
    input  logic                  issue_accepted,
    input  logic [31:0]           seq_pc,
    output logic [31:0]           next_pc,
    output logic                  any_redirect
);
    logic        exc_held;
    logic        ertn_held;
    logic        br_held;
    logic [31:0] exc_target;
    logic [31:0] ertn_target;
    logic [31:0] br_target;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exc_held  <= 1'b0;
            ertn_held <= 1'b0;
            br_held   <= 1'b0;
        end else if (issue_accepted) begin
            exc_held  <= 1'b0;   // target went out with this request.
            ertn_held <= 1'b0;
            br_held   <= 1'b0;
        end else begin
            if (exc.valid)  exc_held  <= 1'b1;
            if (ertn.valid) ertn_held <= 1'b1;
            if (br.taken)   br_held   <= 1'b1;
        end
    end

    // an older held target of the same kind is kept.
    always_ff @(posedge clk) begin
        if (exc.valid && !exc_held)   exc_target  <= exc.target;
        if (ertn.valid && !ertn_held) ertn_target <= ertn.target;
        if (br.taken && !br_held)     br_target   <= br.target;
    end

    assign any_redirect = exc.valid | ertn.valid | br.taken;

    assign next_pc = exc_held   ? exc_target  :
                     exc.valid  ? exc.target  :
                     ertn_held  ? ertn_target :
                     ertn.valid ? ertn.target :
                     br_held    ? br_target   :
                     br.taken   ? br.target   : seq_pc;

endmodule

/* rtl/fetch_pkg.sv */
`include "fetch_config.svh"

package fetch_pkg;

    // ------------------------------------------------------------
    // redirect inputs
    // ------------------------------------------------------------

    // exception entry or exception return.
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    // feedback from decode.
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
        logic        stall;
    } branch_fb_t;

    // ------------------------------------------------------------
    // pipeline payloads
    // ------------------------------------------------------------

    typedef struct packed {
        logic [31:0] pc;
        logic        adef;
        logic [31:0] bad_addr;
    } fetch_req_t;

    typedef struct packed {
        logic [31:0]               pc;
        logic [`FETCH_INST_W-1:0]  inst;
        logic                      adef;
        logic [31:0]               bad_addr;
    } fetch_pkt_t;

    // read side of the instruction sram port.
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } isram_req_t;

endpackage

/* rtl/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// ------------------------------------------------------------
// fetch front end constants
// ------------------------------------------------------------

// first address fetched after reset.
`define FETCH_RESET_PC   32'h1c000000

// instruction word width.
`define FETCH_INST_W     32

// sram size code, word access.
`define FETCH_SRAM_SIZE  2'd2

`endif
